/* source/core_types_pkg.sv */
package core_types_pkg;

	// one machine word, data and byte addresses alike
	localparam int xlen = 32;

	// architectural register count, x0 included
	localparam int reg_count = 32;
	localparam int reg_idx_w = $clog2(reg_count);

	// byte distance from one instruction to the next
	localparam int instr_step = 4;

	typedef logic [xlen-1:0] word_t;
	typedef logic [reg_idx_w-1:0] reg_idx_t;

	// first fetch address out of reset
	localparam word_t reset_pc = 32'h0000_0000;

endpackage

/* source/rv_isa_pkg.sv */
package rv_isa_pkg;

	typedef logic [31:0] instr_t;

	// major opcodes of the supported subset
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;

	// funct3 for register and immediate arithmetic
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll = 3'b001;
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_srl = 3'b101;
	localparam logic [2:0] f3_or = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;

	// word-sized load and store
	localparam logic [2:0] f3_word = 3'b010;

	// branch conditions
	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;

	typedef enum logic [3:0] {
		add, sub, and_op, or_op, xor_op, slt, sll, srl, pass_b
	} alu_op_e;

	typedef enum logic [1:0] {none, load, store} mem_op_e;

endpackage

/* source/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
	import core_types_pkg::*;
	import rv_isa_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  instr_t instruction,
	input  logic   instruction_wait,
	input  logic   fetch_hold,
	input  logic   flush,
	input  word_t  branch_target,
	output logic   instruction_ready,
	output word_t  instruction_address,
	output logic   fd_valid,
	output word_t  fd_pc,
	output instr_t fd_instruction
);

	word_t pc;
	// low through reset, then requesting for good
	logic  request_enable;
	logic  accept;

	// no request while the slot is stuck or the pc is being redirected
	assign instruction_ready = request_enable && !fetch_hold && !flush;
	assign instruction_address = pc;
	assign accept = instruction_ready && !instruction_wait;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= reset_pc;
			request_enable <= 1'b0;
			fd_valid <= 1'b0;
		end else begin
			request_enable <= 1'b1;
			if (flush) begin
				// taken branch, drop the younger word and refetch at the target
				pc <= branch_target;
				fd_valid <= 1'b0;
			end else if (accept) begin
				pc <= pc + word_t'(instr_step);
				fd_valid <= 1'b1;
			end else if (!fetch_hold) begin
				// decode took the slot, nothing new arrived
				fd_valid <= 1'b0;
			end
		end
	end

	// captured word and its address
	always_ff @(posedge clk) begin
		if (accept) begin
			fd_pc <= pc;
			fd_instruction <= instruction;
		end
	end

	// branch targets come from the execute adder, so check alignment here
	pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		instruction_address[1:0] == 2'b00)
		else $error("instruction address not word aligned");

endmodule

/* source/instruction_decoder.sv */
`timescale 1ns/1ps

module instruction_decoder
	import core_types_pkg::*;
	import rv_isa_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     fd_valid,
	input  word_t    fd_pc,
	input  instr_t   fd_instruction,
	input  word_t    operand_a,
	input  word_t    operand_b,
	input  logic     decode_hold,
	input  logic     exec_hold,
	input  logic     flush,
	output reg_idx_t rs1,
	output reg_idx_t rs2,
	output logic     uses_rs2,
	output logic     de_valid,
	output word_t    de_pc,
	output alu_op_e  de_alu_op,
	output mem_op_e  de_mem_op,
	output logic     de_is_branch,
	output logic     de_branch_ne,
	output logic     de_use_imm,
	output reg_idx_t de_rd,
	output word_t    de_a,
	output word_t    de_b,
	output word_t    de_imm
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	// funct7 bit 30 picks sub over add
	logic       alt_bit;
	reg_idx_t   rd;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	logic       supported;
	logic       writes_rd;
	logic       is_branch;
	logic       use_imm;
	alu_op_e    alu_op;
	mem_op_e    mem_op;
	word_t      imm;

	assign opcode = fd_instruction[6:0];
	assign funct3 = fd_instruction[14:12];
	assign alt_bit = fd_instruction[30];
	assign rd = fd_instruction[11:7];
	assign rs1 = fd_instruction[19:15];
	assign rs2 = fd_instruction[24:20];

	// rs2 only matters for these formats, lets hazard_control skip it elsewhere
	assign uses_rs2 = (opcode == op_reg) || (opcode == op_store) || (opcode == op_branch);

	// sign extended immediates per format
	assign imm_i = {{20{fd_instruction[31]}}, fd_instruction[31:20]};
	assign imm_s = {{20{fd_instruction[31]}}, fd_instruction[31:25], fd_instruction[11:7]};
	assign imm_b = {{19{fd_instruction[31]}}, fd_instruction[31], fd_instruction[7],
		fd_instruction[30:25], fd_instruction[11:8], 1'b0};
	assign imm_u = {fd_instruction[31:12], 12'b0};

	always_comb begin
		supported = 1'b1;
		writes_rd = 1'b0;
		is_branch = 1'b0;
		use_imm = 1'b0;
		alu_op = add;
		mem_op = none;
		imm = imm_i;
		case (opcode)
			op_reg: begin
				writes_rd = 1'b1;
				case (funct3)
					f3_add_sub: alu_op = alt_bit ? sub : add;
					f3_sll: alu_op = sll;
					f3_slt: alu_op = slt;
					f3_xor: alu_op = xor_op;
					// sra shares funct3, not in the subset
					f3_srl: begin
						alu_op = srl;
						supported = !alt_bit;
					end
					f3_or: alu_op = or_op;
					f3_and: alu_op = and_op;
					default: supported = 1'b0;
				endcase
			end
			op_imm: begin
				writes_rd = 1'b1;
				use_imm = 1'b1;
				case (funct3)
					f3_add_sub: alu_op = add;
					f3_slt: alu_op = slt;
					f3_xor: alu_op = xor_op;
					f3_or: alu_op = or_op;
					f3_and: alu_op = and_op;
					default: supported = 1'b0;
				endcase
			end
			op_lui: begin
				writes_rd = 1'b1;
				use_imm = 1'b1;
				alu_op = pass_b;
				imm = imm_u;
			end
			// address is rs1 plus offset through the ALU adder
			op_load: begin
				writes_rd = 1'b1;
				use_imm = 1'b1;
				mem_op = load;
				supported = (funct3 == f3_word);
			end
			op_store: begin
				use_imm = 1'b1;
				mem_op = store;
				imm = imm_s;
				supported = (funct3 == f3_word);
			end
			op_branch: begin
				is_branch = 1'b1;
				imm = imm_b;
				supported = (funct3 == f3_beq) || (funct3 == f3_bne);
			end
			default: supported = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			de_valid <= 1'b0;
		end else if (flush) begin
			de_valid <= 1'b0;
		end else if (!exec_hold) begin
			// held decode sends a bubble down while execute moves on
			de_valid <= fd_valid && !decode_hold;
		end
	end

	// unsupported words turn into a no-op with rd zero
	always_ff @(posedge clk) begin
		if (!exec_hold) begin
			de_pc <= fd_pc;
			de_alu_op <= alu_op;
			de_mem_op <= supported ? mem_op : none;
			de_is_branch <= supported && is_branch;
			de_branch_ne <= (funct3 == f3_bne);
			de_use_imm <= use_imm;
			de_rd <= (supported && writes_rd) ? rd : '0;
			de_a <= operand_a;
			de_b <= operand_b;
			de_imm <= imm;
		end
	end

endmodule

/* source/register_file.sv */
`timescale 1ns/1ps

module register_file
	import core_types_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	input  logic     write_enable,
	input  reg_idx_t write_index,
	input  word_t    write_data,
	output word_t    operand_a,
	output word_t    operand_b
);

	word_t regs [reg_count];

	// x0 is cleared by reset and never written, so plain reads give zero
	assign operand_a = regs[rs1];
	assign operand_b = regs[rs2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (write_enable && write_index != '0) begin
			regs[write_index] <= write_data;
		end
	end

	// stores and branches retire with rd zero and still raise write_enable
	x0_stays_zero: assert property (@(posedge clk) disable iff (!rst_n)
		write_enable && write_index == '0 |=> regs[0] == '0)
		else $error("x0 changed after a write to index zero");

endmodule

/* source/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit
	import core_types_pkg::*;
	import rv_isa_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     de_valid,
	input  word_t    de_pc,
	input  alu_op_e  de_alu_op,
	input  mem_op_e  de_mem_op,
	input  logic     de_is_branch,
	input  logic     de_branch_ne,
	input  logic     de_use_imm,
	input  reg_idx_t de_rd,
	input  word_t    de_a,
	input  word_t    de_b,
	input  word_t    de_imm,
	input  logic     exec_hold,
	input  logic     flush,
	output logic     em_valid,
	output reg_idx_t em_rd,
	output mem_op_e  em_mem_op,
	output word_t    em_result,
	output word_t    em_store_data,
	output logic     branch_taken,
	output word_t    branch_target
);

	word_t alu_b;
	word_t alu_result;
	logic  take_branch;

	// second ALU operand, immediate or rs2
	assign alu_b = de_use_imm ? de_imm : de_b;

	always_comb begin
		case (de_alu_op)
			add: alu_result = de_a + alu_b;
			sub: alu_result = de_a - alu_b;
			and_op: alu_result = de_a & alu_b;
			or_op: alu_result = de_a | alu_b;
			xor_op: alu_result = de_a ^ alu_b;
			slt: alu_result = word_t'($signed(de_a) < $signed(alu_b));
			// shift amount is the low five bits
			sll: alu_result = de_a << alu_b[4:0];
			srl: alu_result = de_a >> alu_b[4:0];
			pass_b: alu_result = alu_b;
			default: alu_result = de_a + alu_b;
		endcase
	end

	// beq on equal, bne on not equal
	assign take_branch = de_valid && de_is_branch && ((de_a == de_b) != de_branch_ne);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			em_valid <= 1'b0;
			branch_taken <= 1'b0;
		end else if (flush) begin
			// the branch itself leaves with the flush it caused
			em_valid <= 1'b0;
			branch_taken <= 1'b0;
		end else if (!exec_hold) begin
			em_valid <= de_valid;
			branch_taken <= take_branch;
		end
	end

	always_ff @(posedge clk) begin
		if (!exec_hold) begin
			em_rd <= de_rd;
			em_mem_op <= de_mem_op;
			em_result <= alu_result;
			em_store_data <= de_b;
			branch_target <= de_pc + de_imm;
		end
	end

endmodule

/* source/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage
	import core_types_pkg::*;
	import rv_isa_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     em_valid,
	input  reg_idx_t em_rd,
	input  mem_op_e  em_mem_op,
	input  word_t    em_result,
	input  word_t    em_store_data,
	input  word_t    memory_data_load,
	input  logic     memory_wait,
	output word_t    memory_address,
	output word_t    memory_data_store,
	output logic     memory_read,
	output logic     memory_write,
	output logic     memory_busy,
	output logic     mw_valid,
	output reg_idx_t mw_rd,
	output logic     write_enable,
	output reg_idx_t write_index,
	output word_t    write_data
);

	logic  access;
	word_t mw_data;

	// strobes follow the slot, which stays put until the access ends
	assign memory_read = em_valid && (em_mem_op == load);
	assign memory_write = em_valid && (em_mem_op == store);
	assign access = memory_read || memory_write;
	assign memory_address = em_result;
	assign memory_data_store = em_store_data;

	// unfinished access, everything up front holds
	assign memory_busy = access && memory_wait;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mw_valid <= 1'b0;
		end else begin
			// bubble into write-back while the access is still open
			mw_valid <= em_valid && !memory_busy;
		end
	end

	// load data is sampled in the cycle memory_wait drops
	always_ff @(posedge clk) begin
		mw_rd <= em_rd;
		mw_data <= memory_read ? memory_data_load : em_result;
	end

	// rd zero is dropped by the register file
	assign write_enable = mw_valid;
	assign write_index = mw_rd;
	assign write_data = mw_data;

	strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(memory_read && memory_write))
		else $error("memory read and write high together");

	// the stall must freeze the execute slot that feeds the bus
	access_held: assert property (@(posedge clk) disable iff (!rst_n)
		memory_busy |=> access && $stable(memory_address) && $stable(memory_write))
		else $error("data access changed while memory_wait was high");

endmodule

/* source/hazard_control.sv */
`timescale 1ns/1ps

module hazard_control
	import core_types_pkg::*;
(
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	input  logic     uses_rs2,
	input  logic     fd_valid,
	input  logic     de_valid,
	input  reg_idx_t de_rd,
	input  logic     em_valid,
	input  reg_idx_t em_rd,
	input  logic     mw_valid,
	input  reg_idx_t mw_rd,
	input  logic     memory_busy,
	input  logic     branch_taken,
	output logic     fetch_hold,
	output logic     decode_hold,
	output logic     exec_hold,
	output logic     flush
);

	logic rs1_pending;
	logic rs2_pending;
	logic raw_stall;

	// source still owed by an older instruction, x0 never is
	assign rs1_pending = (rs1 != '0) && (
		(de_valid && de_rd == rs1) ||
		(em_valid && em_rd == rs1) ||
		(mw_valid && mw_rd == rs1));
	assign rs2_pending = uses_rs2 && (rs2 != '0) && (
		(de_valid && de_rd == rs2) ||
		(em_valid && em_rd == rs2) ||
		(mw_valid && mw_rd == rs2));

	// no forwarding, decode waits out the write-back edge
	assign raw_stall = fd_valid && (rs1_pending || rs2_pending);

	// an open data access stalls every stage in front of it
	assign exec_hold = memory_busy;
	assign decode_hold = raw_stall || memory_busy;
	assign fetch_hold = decode_hold;

	// taken branch clears fetch/decode and decode/execute
	assign flush = branch_taken;

endmodule

/* source/pipeline_core.sv */
`timescale 1ns/1ps

module pipeline_core
	import core_types_pkg::*;
	import rv_isa_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  instr_t instruction,
	input  logic   instruction_wait,
	input  word_t  memory_data_load,
	input  logic   memory_wait,
	output logic   instruction_ready,
	output word_t  instruction_address,
	output word_t  memory_address,
	output word_t  memory_data_store,
	output logic   memory_read,
	output logic   memory_write
);

	// fetch/decode slot
	logic     fd_valid;
	word_t    fd_pc;
	instr_t   fd_instruction;

	// decode/execute slot and register reads
	reg_idx_t rs1;
	reg_idx_t rs2;
	logic     uses_rs2;
	word_t    operand_a;
	word_t    operand_b;
	logic     de_valid;
	word_t    de_pc;
	alu_op_e  de_alu_op;
	mem_op_e  de_mem_op;
	logic     de_is_branch;
	logic     de_branch_ne;
	logic     de_use_imm;
	reg_idx_t de_rd;
	word_t    de_a;
	word_t    de_b;
	word_t    de_imm;

	// execute/memory slot
	logic     em_valid;
	reg_idx_t em_rd;
	mem_op_e  em_mem_op;
	word_t    em_result;
	word_t    em_store_data;
	logic     branch_taken;
	word_t    branch_target;

	// memory/write-back slot and register write port
	logic     memory_busy;
	logic     mw_valid;
	reg_idx_t mw_rd;
	logic     write_enable;
	reg_idx_t write_index;
	word_t    write_data;

	// stall and flush
	logic     fetch_hold;
	logic     decode_hold;
	logic     exec_hold;
	logic     flush;

	fetch_unit fetch (
		.clk                 (clk),
		.rst_n               (rst_n),
		.instruction         (instruction),
		.instruction_wait    (instruction_wait),
		.fetch_hold          (fetch_hold),
		.flush               (flush),
		.branch_target       (branch_target),
		.instruction_ready   (instruction_ready),
		.instruction_address (instruction_address),
		.fd_valid            (fd_valid),
		.fd_pc               (fd_pc),
		.fd_instruction      (fd_instruction)
	);

	instruction_decoder decoder (
		.clk            (clk),
		.rst_n          (rst_n),
		.fd_valid       (fd_valid),
		.fd_pc          (fd_pc),
		.fd_instruction (fd_instruction),
		.operand_a      (operand_a),
		.operand_b      (operand_b),
		.decode_hold    (decode_hold),
		.exec_hold      (exec_hold),
		.flush          (flush),
		.rs1            (rs1),
		.rs2            (rs2),
		.uses_rs2       (uses_rs2),
		.de_valid       (de_valid),
		.de_pc          (de_pc),
		.de_alu_op      (de_alu_op),
		.de_mem_op      (de_mem_op),
		.de_is_branch   (de_is_branch),
		.de_branch_ne   (de_branch_ne),
		.de_use_imm     (de_use_imm),
		.de_rd          (de_rd),
		.de_a           (de_a),
		.de_b           (de_b),
		.de_imm         (de_imm)
	);

	register_file registers (
		.clk          (clk),
		.rst_n        (rst_n),
		.rs1          (rs1),
		.rs2          (rs2),
		.write_enable (write_enable),
		.write_index  (write_index),
		.write_data   (write_data),
		.operand_a    (operand_a),
		.operand_b    (operand_b)
	);

	execute_unit execute (
		.clk           (clk),
		.rst_n         (rst_n),
		.de_valid      (de_valid),
		.de_pc         (de_pc),
		.de_alu_op     (de_alu_op),
		.de_mem_op     (de_mem_op),
		.de_is_branch  (de_is_branch),
		.de_branch_ne  (de_branch_ne),
		.de_use_imm    (de_use_imm),
		.de_rd         (de_rd),
		.de_a          (de_a),
		.de_b          (de_b),
		.de_imm        (de_imm),
		.exec_hold     (exec_hold),
		.flush         (flush),
		.em_valid      (em_valid),
		.em_rd         (em_rd),
		.em_mem_op     (em_mem_op),
		.em_result     (em_result),
		.em_store_data (em_store_data),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	memory_stage memory (
		.clk               (clk),
		.rst_n             (rst_n),
		.em_valid          (em_valid),
		.em_rd             (em_rd),
		.em_mem_op         (em_mem_op),
		.em_result         (em_result),
		.em_store_data     (em_store_data),
		.memory_data_load  (memory_data_load),
		.memory_wait       (memory_wait),
		.memory_address    (memory_address),
		.memory_data_store (memory_data_store),
		.memory_read       (memory_read),
		.memory_write      (memory_write),
		.memory_busy       (memory_busy),
		.mw_valid          (mw_valid),
		.mw_rd             (mw_rd),
		.write_enable      (write_enable),
		.write_index       (write_index),
		.write_data        (write_data)
	);

	hazard_control hazards (
		.rs1          (rs1),
		.rs2          (rs2),
		.uses_rs2     (uses_rs2),
		.fd_valid     (fd_valid),
		.de_valid     (de_valid),
		.de_rd        (de_rd),
		.em_valid     (em_valid),
		.em_rd        (em_rd),
		.mw_valid     (mw_valid),
		.mw_rd        (mw_rd),
		.memory_busy  (memory_busy),
		.branch_taken (branch_taken),
		.fetch_hold   (fetch_hold),
		.decode_hold  (decode_hold),
		.exec_hold    (exec_hold),
		.flush        (flush)
	);

endmodule

/* sim/program_table.svh */
// number of rows in the expected store table
localparam int store_count = 19;

// expected stores in program order, each row is {address, data}
logic [63:0] expected_stores [store_count] = '{
	// register-register results of x1 = 25 and x2 = 7
	{32'h0000_0040, 32'h0000_0020},
	{32'h0000_0044, 32'h0000_0012},
	{32'h0000_0048, 32'h0000_0001},
	{32'h0000_004c, 32'h0000_001f},
	{32'h0000_0050, 32'h0000_001e},
	{32'h0000_0054, 32'h0000_0001},
	{32'h0000_0058, 32'h0000_0380},
	{32'h0000_005c, 32'h0000_0007},
	// immediate ops and lui
	{32'h0000_0060, 32'hffff_fffb},
	{32'h0000_0064, 32'h0000_0001},
	{32'h0000_0068, 32'h0000_0008},
	{32'h0000_006c, 32'h0000_0037},
	{32'h0000_0070, 32'h0000_0004},
	{32'h0000_0074, 32'h1234_5000},
	// dependent chain, then store, load and store again
	{32'h0000_0078, 32'h1234_5687},
	{32'h0000_007c, 32'h1234_5687},
	{32'h0000_0080, 32'h1234_56a0},
	// only the stores behind not-taken branches
	{32'h0000_0084, 32'h0000_0019},
	{32'h0000_0090, 32'h0000_0007}
};

// test program, word i sits at reset_pc + 4 * i
task automatic load_program();
	for (int i = 0; i < program_words; i++) begin
		program_mem[i] = nop_word;
	end
	program_mem[0] = imm_op(op_imm, f3_add_sub, 1, 0, 25);
	program_mem[1] = imm_op(op_imm, f3_add_sub, 2, 0, 7);
	// each result depends on the line before, so decode has to stall
	program_mem[2] = reg_op(f3_add_sub, 1'b0, 3, 1, 2);
	program_mem[3] = store_op(3, 0, 12'h040);
	program_mem[4] = reg_op(f3_add_sub, 1'b1, 4, 1, 2);
	program_mem[5] = store_op(4, 0, 12'h044);
	program_mem[6] = reg_op(f3_and, 1'b0, 5, 1, 2);
	program_mem[7] = store_op(5, 0, 12'h048);
	program_mem[8] = reg_op(f3_or, 1'b0, 6, 1, 2);
	program_mem[9] = store_op(6, 0, 12'h04c);
	program_mem[10] = reg_op(f3_xor, 1'b0, 7, 1, 2);
	program_mem[11] = store_op(7, 0, 12'h050);
	program_mem[12] = reg_op(f3_slt, 1'b0, 8, 2, 1);
	program_mem[13] = store_op(8, 0, 12'h054);
	program_mem[14] = reg_op(f3_sll, 1'b0, 9, 2, 2);
	program_mem[15] = store_op(9, 0, 12'h058);
	program_mem[16] = reg_op(f3_srl, 1'b0, 10, 9, 2);
	program_mem[17] = store_op(10, 0, 12'h05c);
	// x12 = -5
	program_mem[18] = imm_op(op_imm, f3_add_sub, 12, 0, 12'hffb);
	program_mem[19] = imm_op(op_imm, f3_slt, 13, 12, 12'h000);
	program_mem[20] = imm_op(op_imm, f3_and, 14, 1, 12'h00c);
	program_mem[21] = imm_op(op_imm, f3_or, 15, 2, 12'h030);
	program_mem[22] = imm_op(op_imm, f3_xor, 16, 12, 12'hfff);
	program_mem[23] = upper_op(17, 20'h12345);
	program_mem[24] = store_op(12, 0, 12'h060);
	program_mem[25] = store_op(13, 0, 12'h064);
	program_mem[26] = store_op(14, 0, 12'h068);
	program_mem[27] = store_op(15, 0, 12'h06c);
	program_mem[28] = store_op(16, 0, 12'h070);
	program_mem[29] = store_op(17, 0, 12'h074);
	program_mem[30] = imm_op(op_imm, f3_add_sub, 18, 17, 12'h678);
	program_mem[31] = imm_op(op_imm, f3_xor, 18, 18, 12'h0ff);
	program_mem[32] = store_op(18, 0, 12'h078);
	program_mem[33] = imm_op(op_load, f3_word, 19, 0, 12'h078);
	program_mem[34] = store_op(19, 0, 12'h07c);
	program_mem[35] = imm_op(op_load, f3_word, 20, 0, 12'h07c);
	program_mem[36] = reg_op(f3_add_sub, 1'b0, 21, 20, 1);
	program_mem[37] = store_op(21, 0, 12'h080);
	// not taken, taken, taken, not taken
	program_mem[38] = branch_op(f3_beq, 1, 2, 13'd8);
	program_mem[39] = store_op(1, 0, 12'h084);
	program_mem[40] = branch_op(f3_bne, 1, 2, 13'd8);
	program_mem[41] = store_op(2, 0, 12'h088);
	program_mem[42] = branch_op(f3_beq, 3, 3, 13'd8);
	program_mem[43] = store_op(3, 0, 12'h08c);
	program_mem[44] = branch_op(f3_bne, 2, 2, 13'd8);
	program_mem[45] = store_op(2, 0, 12'h090);
	// park the core on a branch to itself
	program_mem[46] = branch_op(f3_beq, 0, 0, 13'd0);
endtask

/* sim/pipeline_core_tb.sv */
`timescale 1ns/1ps

module pipeline_core_tb
	import core_types_pkg::*;
	import rv_isa_pkg::*;
();

	localparam time clk_period = 100ns;
	localparam time drive_delay = 5ns;
	localparam time sample_delay = 20ns;
	localparam int reset_cycles = 10;
	localparam int program_words = 64;
	localparam int data_words = 64;
	// the first request is due in the first cycle after reset
	localparam int request_timeout = 1;
	localparam int store_timeout = 300;
	localparam int quiet_cycles = 40;
	localparam logic [31:0] seed = 32'hec1f7138;
	// addi x0, x0, 0
	localparam instr_t nop_word = 32'h0000_0013;

	logic   clk;
	logic   rst_n;
	instr_t instruction;
	logic   instruction_wait;
	word_t  memory_data_load;
	logic   memory_wait;
	logic   instruction_ready;
	word_t  instruction_address;
	word_t  memory_address;
	word_t  memory_data_store;
	logic   memory_read;
	logic   memory_write;

	// memory models and the store log they feed
	instr_t program_mem [program_words];
	word_t  data_mem [data_words];
	word_t  store_addresses [$];
	word_t  store_values [$];
	word_t  fetch_address;
	int     fetch_wait_left;
	int     data_wait_left;
	logic   data_pending;

	int     error_count = 0;
	int     stores_checked = 0;
	logic   timed_out;

	// instruction encoders, field order from the RV32I base formats
	function automatic instr_t reg_op(logic [2:0] funct3, logic alt, reg_idx_t rd,
		reg_idx_t rs1, reg_idx_t rs2);
		return {1'b0, alt, 5'b0, rs2, rs1, funct3, rd, op_reg};
	endfunction

	function automatic instr_t imm_op(logic [6:0] opcode, logic [2:0] funct3, reg_idx_t rd,
		reg_idx_t rs1, logic [11:0] imm);
		return {imm, rs1, funct3, rd, opcode};
	endfunction

	function automatic instr_t store_op(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] offset);
		return {offset[11:5], rs2, rs1, f3_word, offset[4:0], op_store};
	endfunction

	function automatic instr_t branch_op(logic [2:0] funct3, reg_idx_t rs1, reg_idx_t rs2,
		logic [12:0] offset);
		return {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11], op_branch};
	endfunction

	function automatic instr_t upper_op(reg_idx_t rd, logic [19:0] imm);
		return {imm, rd, op_lui};
	endfunction

	`include "program_table.svh"

	pipeline_core UUT (
		.clk                 (clk),
		.rst_n               (rst_n),
		.instruction         (instruction),
		.instruction_wait    (instruction_wait),
		.memory_data_load    (memory_data_load),
		.memory_wait         (memory_wait),
		.instruction_ready   (instruction_ready),
		.instruction_address (instruction_address),
		.memory_address      (memory_address),
		.memory_data_store   (memory_data_store),
		.memory_read         (memory_read),
		.memory_write        (memory_write)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(clk_period / 2);
			clk = ~clk;
		end
	end

	// words past the program read as nop
	function automatic instr_t fetch_word(word_t address);
		if (address >= word_t'(program_words * instr_step)) begin
			return nop_word;
		end
		return program_mem[address >> 2];
	endfunction

	// a new address starts a new random wait of 0 to 3 cycles
	task automatic answer_fetch();
		if (instruction_address !== fetch_address) begin
			fetch_address = instruction_address;
			fetch_wait_left = $urandom % 4;
		end
		instruction = fetch_word(instruction_address);
		if (fetch_wait_left > 0) begin
			instruction_wait = 1'b1;
			fetch_wait_left--;
		end else begin
			instruction_wait = 1'b0;
		end
	endtask

	// strobes come from stage registers, so they are settled here
	task automatic answer_data();
		logic in_range;
		in_range = memory_address < word_t'(data_words * 4);
		memory_data_load = 'x;
		if (memory_read || memory_write) begin
			if (!data_pending) begin
				data_pending = 1'b1;
				data_wait_left = $urandom % 4;
			end
			if (data_wait_left > 0) begin
				memory_wait = 1'b1;
				data_wait_left--;
			end else begin
				// wait low, the access ends at the next edge
				memory_wait = 1'b0;
				data_pending = 1'b0;
				if (!in_range) begin
					$display("data access at address %h is outside the model memory",
						memory_address);
					error_count++;
				end
				if (memory_write) begin
					store_addresses.push_back(memory_address);
					store_values.push_back(memory_data_store);
					if (in_range) begin
						data_mem[memory_address >> 2] = memory_data_store;
					end
				end else if (in_range) begin
					memory_data_load = data_mem[memory_address >> 2];
				end
			end
		end else begin
			memory_wait = 1'b0;
			data_pending = 1'b0;
		end
	endtask

	// both memory models, driven just after each rising edge
	initial begin
		word_t address;
		void'($urandom(seed));
		fetch_address = 'x;
		fetch_wait_left = 0;
		data_wait_left = 0;
		data_pending = 1'b0;
		// fill pattern built from the full byte address
		for (int i = 0; i < data_words; i++) begin
			address = word_t'(i * 4);
			data_mem[i] = ~address ^ 32'h3c3c_0000;
		end
		forever begin
			@(posedge clk);
			#drive_delay;
			answer_data();
			answer_fetch();
		end
	end

	task automatic check_idle(logic ready, logic read, logic write);
		if (ready !== 1'b0 || read !== 1'b0 || write !== 1'b0) begin
			$display("** Error at %0t: outputs not idle, ready %b read %b write %b",
				$time, ready, read, write);
			error_count++;
		end
	endtask

	task automatic check_request(word_t address, word_t expected);
		if (address !== expected) begin
			$display("** Error at %0t: first request at %h, expected %h",
				$time, address, expected);
			error_count++;
		end
	endtask

	// compares the oldest logged store with one table row
	task automatic check_store(word_t address, word_t data);
		word_t seen_address;
		word_t seen_data;
		seen_address = store_addresses.pop_front();
		seen_data = store_values.pop_front();
		stores_checked++;
		if (seen_address !== address || seen_data !== data) begin
			$display("** Error at %0t: store %0d wrote %h to %h, expected %h to %h",
				$time, stores_checked, seen_data, seen_address, data, address);
			error_count++;
		end
	endtask

	// rst_n low through ten edges, released just after the last one
	task automatic apply_reset();
		for (int i = 0; i < reset_cycles; i++) begin
			@(posedge clk);
			#drive_delay;
			if (i == reset_cycles - 1) begin
				rst_n = 1'b1;
			end
			#(sample_delay - drive_delay);
			check_idle(instruction_ready, memory_read, memory_write);
		end
	endtask

	task automatic wait_first_request();
		int cycles;
		cycles = 0;
		while (instruction_ready !== 1'b1 && cycles < request_timeout) begin
			@(posedge clk);
			#sample_delay;
			cycles++;
		end
		if (instruction_ready !== 1'b1) begin
			$display("instruction_ready did not rise within %0d cycles after reset",
				request_timeout);
			error_count++;
			timed_out = 1'b1;
		end else begin
			check_request(instruction_address, reset_pc);
		end
	endtask

	task automatic wait_for_store(int number);
		int cycles;
		cycles = 0;
		while (store_addresses.size() == 0 && cycles < store_timeout) begin
			@(posedge clk);
			#sample_delay;
			cycles++;
		end
		if (store_addresses.size() == 0) begin
			$display("no store %0d within %0d cycles", number, store_timeout);
			error_count++;
			timed_out = 1'b1;
		end
	endtask

	// skipped stores must never show up once the core is parked
	task automatic watch_for_extra_stores();
		for (int i = 0; i < quiet_cycles; i++) begin
			@(posedge clk);
			#sample_delay;
		end
		if (store_addresses.size() != 0) begin
			$display("%0d stores beyond the expected sequence, the first at address %h",
				store_addresses.size(), store_addresses[0]);
			error_count++;
		end
	endtask

	initial begin
		rst_n = 1'b0;
		instruction = nop_word;
		instruction_wait = 1'b0;
		memory_data_load = '0;
		memory_wait = 1'b0;
		timed_out = 1'b0;
		load_program();
		apply_reset();
		wait_first_request();
		for (int i = 0; i < store_count; i++) begin
			if (!timed_out) begin
				wait_for_store(i);
				if (!timed_out) begin
					check_store(expected_stores[i][63:32], expected_stores[i][31:0]);
				end
			end
		end
		if (!timed_out) begin
			watch_for_extra_stores();
		end
		$display("errors: %0d, stores checked: %0d of %0d",
			error_count, stores_checked, store_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* list.f */
+incdir+sim
source/core_types_pkg.sv
source/rv_isa_pkg.sv
source/fetch_unit.sv
source/instruction_decoder.sv
source/register_file.sv
source/execute_unit.sv
source/memory_stage.sv
source/hazard_control.sv
source/pipeline_core.sv
sim/pipeline_core_tb.sv

/* Bender.yml */
package:
  name: pipeline_core

sources:
  - source/core_types_pkg.sv
  - source/rv_isa_pkg.sv
  - source/fetch_unit.sv
  - source/instruction_decoder.sv
  - source/register_file.sv
  - source/execute_unit.sv
  - source/memory_stage.sv
  - source/hazard_control.sv
  - source/pipeline_core.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/pipeline_core_tb.sv
